//--- dv/lease_cache_checker.sv
`timescale 1ns/1ns

// bus and handshake properties, bound into lease_cache_top
module lease_cache_checker (
	input logic                                   clock_i,
	input logic                                   reset_i,
	input logic                                   mem_cyc_i,
	input logic                                   mem_stb_i,
	input logic                                   mem_we_i,
	input logic [lease_cache_pkg::WORD_ADDR_W-1:0] mem_adr_i,
	input logic [lease_cache_pkg::DATA_W-1:0]      mem_wdat_i,   // write data out of the top
	input logic                                   mem_ack_i,
	input logic                                   core0_done_i,
	input logic                                   core1_done_i
);

	int fail_count = 0;   // assertion failures so far

	stb_needs_cyc: assert property (@(posedge clock_i) disable iff (reset_i)
		mem_stb_i |-> mem_cyc_i)
		else begin
			$error("mem_stb_o high while mem_cyc_o low");
			fail_count++;
		end

	ack_in_cycle: assert property (@(posedge clock_i) disable iff (reset_i)
		mem_ack_i |-> (mem_cyc_i && mem_stb_i))
		else begin
			$error("mem_ack_i outside of an active strobe");
			fail_count++;
		end

	// request fields frozen until the slave answers
	req_stable: assert property (@(posedge clock_i) disable iff (reset_i)
		(mem_stb_i && !mem_ack_i) |=>
			(mem_stb_i && $stable(mem_adr_i) && $stable(mem_we_i) && $stable(mem_wdat_i)))
		else begin
			$error("memory request changed before mem_ack_i");
			fail_count++;
		end

	done0_pulse: assert property (@(posedge clock_i) disable iff (reset_i)
		core0_done_i |=> !core0_done_i)
		else begin
			$error("core0_done_o high for two cycles");
			fail_count++;
		end

	done1_pulse: assert property (@(posedge clock_i) disable iff (reset_i)
		core1_done_i |=> !core1_done_i)
		else begin
			$error("core1_done_o high for two cycles");
			fail_count++;
		end

endmodule

bind lease_cache_top lease_cache_checker checker_i (
	.clock_i      (clock_i),
	.reset_i      (reset_i),
	.mem_cyc_i    (mem_cyc_o),
	.mem_stb_i    (mem_stb_o),
	.mem_we_i     (mem_we_o),
	.mem_adr_i    (mem_adr_o),
	.mem_wdat_i   (mem_dat_o),
	.mem_ack_i    (mem_ack_i),
	.core0_done_i (core0_done_o),
	.core1_done_i (core1_done_o)
);

//--- dv/lease_cache_monitor.sv
`timescale 1ns/1ns

// compares core completions and perf readouts with expected values
module lease_cache_monitor (
	input logic        clock_i,
	input logic        reset_i,
	input logic        core0_done_i,
	input logic [31:0] core0_rdata_i,
	input logic        core1_done_i,
	input logic [31:0] core1_rdata_i,
	input logic [31:0] perf0_i,
	input logic [31:0] perf1_i
);
	import lease_cache_pkg::*;

	int errors = 0;
	int checks = 0;

	// outstanding ops per core, {is_read, addr, expected data}
	logic [48:0] pend0_q [$];
	logic [48:0] pend1_q [$];

	task automatic expect_op(input int core, input logic is_read, input logic [15:0] addr,
		input logic [31:0] data);
		if (core == 0)
			pend0_q.push_back({is_read, addr, data});
		else
			pend1_q.push_back({is_read, addr, data});
	endtask

	task automatic finish_op(input int core, input logic [31:0] rdata);
		logic [48:0] e;
		logic        empty;
		empty = (core == 0) ? (pend0_q.size() == 0) : (pend1_q.size() == 0);
		if (empty) begin
			$display("core%0d raised done with no request outstanding", core);
			errors++;
		end else begin
			if (core == 0)
				e = pend0_q.pop_front();
			else
				e = pend1_q.pop_front();
			if (!e[48]) begin
				$display("core%0d write %04h done", core, e[47:32]);  // nothing to compare
			end else begin
				checks++;
				if (rdata === e[31:0]) begin
					$display("core%0d read  %04h = %08h ok", core, e[47:32], rdata);
				end else begin
					$display("[ERROR] core%0d_rdata_o addr %04h exp %08h got %08h",
						core, e[47:32], e[31:0], rdata);
					errors++;
				end
			end
		end
	endtask

	// called once perf_sel has been stable for a cycle
	task automatic check_perf(input int core, input perf_sel_e sel, input logic [31:0] expv);
		logic [31:0] got;
		got = (core == 0) ? perf0_i : perf1_i;
		checks++;
		if (got === expv) begin
			$display("core%0d counter %s = %0d ok", core, sel.name(), got);
		end else begin
			$display("[ERROR] perf%0d_o sel %s exp %08h got %08h", core, sel.name(), expv, got);
			errors++;
		end
	endtask

	// done and rdata are registered in the DUT, pre-edge values are stable
	always @(posedge clock_i) begin
		if (!reset_i && core0_done_i)
			finish_op(0, core0_rdata_i);
	end

	always @(posedge clock_i) begin
		if (!reset_i && core1_done_i)
			finish_op(1, core1_rdata_i);
	end

endmodule

//--- dv/lease_cache_tb.sv
`timescale 1ns/1ns

module lease_cache_tb;
	import lease_cache_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int MAX_LINES  = 64;
	localparam int COLS       = 7;   // hex words per vector line

	logic        clock, reset;
	logic        core0_req, core0_we, core0_done;
	logic [15:0] core0_addr;
	logic [31:0] core0_wdata, core0_rdata;
	logic [7:0]  core0_lease;
	logic        core1_req, core1_we, core1_done;
	logic [15:0] core1_addr;
	logic [31:0] core1_wdata, core1_rdata;
	logic [7:0]  core1_lease;
	perf_sel_e   perf0_sel, perf1_sel;
	logic [31:0] perf0, perf1;
	logic        mem_cyc, mem_stb, mem_we, mem_ack;
	logic [15:0] mem_adr;
	logic [31:0] mem_dat_w, mem_dat_r;

	// vector table
	logic [31:0] vec_mem [MAX_LINES*COLS];
	int          op_core  [MAX_LINES];
	logic        op_we    [MAX_LINES];
	logic [15:0] op_addr  [MAX_LINES];
	logic [31:0] op_data  [MAX_LINES];
	logic [7:0]  op_lease [MAX_LINES];
	logic [31:0] op_exp   [MAX_LINES];
	logic [31:0] perf_exp [2][4];
	int          n_lines, n_ops, n_perf;
	logic        loaded;
	int          tb_errors, total;

	// memory model state
	logic [31:0] mem_words [65536];
	logic        mem_pend;
	int unsigned mem_wait;

	lease_cache_top #(.CACHE_SETS(4)) lease_cache_top_i (
		.clock_i (clock), .reset_i (reset),
		.core0_req_i (core0_req), .core0_we_i (core0_we), .core0_addr_i (core0_addr),
		.core0_wdata_i (core0_wdata), .core0_lease_i (core0_lease),
		.core0_done_o (core0_done), .core0_rdata_o (core0_rdata),
		.core1_req_i (core1_req), .core1_we_i (core1_we), .core1_addr_i (core1_addr),
		.core1_wdata_i (core1_wdata), .core1_lease_i (core1_lease),
		.core1_done_o (core1_done), .core1_rdata_o (core1_rdata),
		.perf0_sel_i (perf0_sel), .perf0_o (perf0),
		.perf1_sel_i (perf1_sel), .perf1_o (perf1),
		.mem_cyc_o (mem_cyc), .mem_stb_o (mem_stb), .mem_we_o (mem_we),
		.mem_adr_o (mem_adr), .mem_dat_o (mem_dat_w),
		.mem_dat_i (mem_dat_r), .mem_ack_i (mem_ack)
	);

	lease_cache_monitor monitor_i (
		.clock_i (clock), .reset_i (reset),
		.core0_done_i (core0_done), .core0_rdata_i (core0_rdata),
		.core1_done_i (core1_done), .core1_rdata_i (core1_rdata),
		.perf0_i (perf0), .perf1_i (perf1)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD/2) clock = ~clock;
	end

	// ------------------------------------------------------------------
	// wishbone memory, ack after 1 to 4 cycles
	// ------------------------------------------------------------------
	initial begin
		void'($urandom(8078));                            // ack delays come from here
		forever begin
			@(posedge clock);
			if (reset) begin
				mem_ack  <= 1'b0;
				mem_pend = 1'b0;
			end else begin
				mem_ack <= 1'b0;
				if (!mem_ack && mem_cyc && mem_stb) begin   // skip the ack cycle itself
					if (!mem_pend) begin
						mem_pend = 1'b1;
						mem_wait = 1 + ($urandom % 4);
					end
					mem_wait--;
					if (mem_wait == 0) begin
						mem_pend = 1'b0;
						mem_ack  <= 1'b1;
						if (mem_we)
							mem_words[mem_adr] <= mem_dat_w;
						else
							mem_dat_r <= mem_words[mem_adr];
					end
				end
			end
		end
	end

	// kind 0 is an access, kind 1 a counter expectation, f ends the table
	task automatic load_vectors();
		logic [31:0] kind;
		int          base;
		$readmemh("dv/lease_cache_vectors.txt", vec_mem);
		for (int i = 0; i < MAX_LINES; i++) begin
			base = i * COLS;
			kind = vec_mem[base];
			if ($isunknown(kind) || kind == 32'hf)
				break;
			n_lines++;
			if (kind == 0) begin
				op_core[n_ops]  = vec_mem[base+1];
				op_we[n_ops]    = vec_mem[base+2][0];
				op_addr[n_ops]  = vec_mem[base+3][15:0];
				op_data[n_ops]  = vec_mem[base+4];
				op_lease[n_ops] = vec_mem[base+5][7:0];
				op_exp[n_ops]   = vec_mem[base+6];
				n_ops++;
			end else begin
				perf_exp[vec_mem[base+1][0]][vec_mem[base+2][1:0]] = vec_mem[base+6];
				n_perf++;
			end
		end
	endtask

	task automatic drive_req(input int c, input int i);
		if (c == 0) begin
			core0_req   <= 1'b1;
			core0_we    <= op_we[i];
			core0_addr  <= op_addr[i];
			core0_wdata <= op_data[i];
			core0_lease <= op_lease[i];
		end else begin
			core1_req   <= 1'b1;
			core1_we    <= op_we[i];
			core1_addr  <= op_addr[i];
			core1_wdata <= op_data[i];
			core1_lease <= op_lease[i];
		end
	endtask

	task automatic wait_done(input int c);
		logic seen;
		seen = 1'b0;
		while (!seen) begin
			@(posedge clock);
			seen = (c == 0) ? core0_done : core1_done;
		end
		if (c == 0)       // drop before the cache is back in idle
			core0_req <= 1'b0;
		else
			core1_req <= 1'b0;
	endtask

	// one core's ops in file order
	task automatic run_core(input int c);
		for (int i = 0; i < n_ops; i++) begin
			if (op_core[i] == c) begin
				@(posedge clock);
				drive_req(c, i);
				monitor_i.expect_op(c, !op_we[i], op_addr[i], op_exp[i]);
				wait_done(c);
			end
		end
	endtask

	task automatic check_counters();
		for (int s = 0; s < 4; s++) begin
			@(posedge clock);
			perf0_sel <= perf_sel_e'(s);
			perf1_sel <= perf_sel_e'(s);
			@(posedge clock);
			monitor_i.check_perf(0, perf_sel_e'(s), perf_exp[0][s]);
			monitor_i.check_perf(1, perf_sel_e'(s), perf_exp[1][s]);
		end
	endtask

	// ------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------
	initial begin
		reset = 1'b1;
		{core0_req, core0_we, core0_addr, core0_wdata, core0_lease} = '0;
		{core1_req, core1_we, core1_addr, core1_wdata, core1_lease} = '0;
		perf0_sel = PERF_HIT;
		perf1_sel = PERF_HIT;
		mem_ack   = 1'b0;
		mem_dat_r = '0;
		{n_lines, n_ops, n_perf, tb_errors} = '0;
		loaded = 1'b0;
		for (int a = 0; a < 65536; a++)
			mem_words[a] = 32'hA5A5_0000 ^ a;   // every word tagged by its address
		load_vectors();
		if (n_ops == 0 || n_perf != 8) begin
			$display("vector file gave %0d operations and %0d counter lines, need 8 counter lines",
				n_ops, n_perf);
			tb_errors++;
		end
		loaded = 1'b1;
		repeat (16) @(posedge clock);
		reset <= 1'b0;
		fork
			run_core(0);
			run_core(1);
		join
		check_counters();
		repeat (2) @(posedge clock);
		total = tb_errors + monitor_i.errors + lease_cache_top_i.checker_i.fail_count;
		$display("%0d operations, %0d checks, %0d errors", n_ops, monitor_i.checks, total);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

	// watchdog, 200 cycles per vector line
	initial begin
		wait (loaded);
		repeat (16 + 200 * (n_lines + 1)) @(posedge clock);
		$display("timeout: operations still running after %0d cycles", 200 * (n_lines + 1));
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

//--- dv/lease_cache_vectors.txt
// kind core op addr data lease expect, all hex; kind 0 access, 1 counter check, f end
// op is 0 read 1 write for kind 0, counter select for kind 1; expect unused on writes
0 0 0 0000 00000000 05 a5a50000
0 0 0 0001 00000000 05 a5a50001
0 0 1 0002 11111111 05 00000000
0 0 0 0002 00000000 05 11111111
0 0 0 0010 00000000 01 a5a50010
0 0 0 0020 00000000 03 a5a50020
0 0 0 0030 00000000 03 a5a50030
0 0 0 0010 00000000 04 a5a50010
0 0 0 0040 00000000 04 a5a50040
0 0 0 0002 00000000 02 11111111
0 0 0 0050 00000000 00 a5a50050
0 0 0 0050 00000000 00 a5a50050
0 0 1 0051 22222222 00 00000000
0 0 0 0051 00000000 02 22222222
0 0 0 0003 00000000 02 a5a50003
0 0 1 0041 33333333 00 00000000
0 0 0 0041 00000000 03 33333333
0 1 1 1004 44444444 02 00000000
0 1 0 1004 00000000 02 44444444
0 1 0 1104 00000000 01 a5a51104
0 1 0 1204 00000000 01 a5a51204
0 1 0 1304 00000000 01 a5a51304
0 1 0 1004 00000000 03 44444444
0 1 0 1005 00000000 03 a5a51005
0 1 0 1008 00000000 02 a5a51008
0 1 0 1008 00000000 02 a5a51008
1 0 0 0000 00000000 00 00000006
1 0 1 0000 00000000 00 0000000b
1 0 2 0000 00000000 00 00000001
1 0 3 0000 00000000 00 00000003
1 1 0 0000 00000000 00 00000003
1 1 1 0000 00000000 00 00000006
1 1 2 0000 00000000 00 00000001
1 1 3 0000 00000000 00 00000002
f 0 0 0000 00000000 00 00000000

//--- lease_cache.f
source/lease_cache_pkg.sv
source/wb_if.sv
source/lease_tag_store.sv
source/lease_cache_controller.sv
source/lease_cache_4w.sv
source/wb_arbiter.sv
source/lease_cache_top.sv
dv/lease_cache_checker.sv
dv/lease_cache_monitor.sv
dv/lease_cache_tb.sv

//--- source/lease_cache_4w.sv
`timescale 1ns/1ns

module lease_cache_4w #(
	parameter int CACHE_SETS = 16
)(
	input  logic                                   clock_i,
	input  logic                                   reset_i,
	input  logic                                   core_req_i,
	input  logic                                   core_we_i,
	input  logic [lease_cache_pkg::WORD_ADDR_W-1:0] core_addr_i,
	input  logic [lease_cache_pkg::DATA_W-1:0]      core_wdata_i,
	input  logic [lease_cache_pkg::LEASE_W-1:0]     core_lease_i,
	output logic                                   core_done_o,
	output logic [lease_cache_pkg::DATA_W-1:0]      core_rdata_o,
	input  lease_cache_pkg::perf_sel_e             perf_sel_i,
	output logic [31:0]                            perf_o,
	wb_if.master                                   wb
);
	import lease_cache_pkg::*;

	localparam int DA_W  = set_idx_bits(CACHE_SETS) + WAY_W + BLOCK_W;
	localparam int DEPTH = CACHE_SETS * WAYS * (1 << BLOCK_W);

	tag_req_t          tag_req;
	tag_rsp_t          tag_rsp;
	logic [DA_W-1:0]   data_addr;
	logic              data_we;
	logic [DATA_W-1:0] data_wdata, data_rdata_q;
	logic [3:0]        evt;                           // indexed by perf_sel_e
	logic [3:0][31:0]  cnt_q;

	// tag, valid, dirty and lease
	// ------------------------------------------------------------------
	lease_tag_store #(.CACHE_SETS(CACHE_SETS)) tag_store_i (
		.clock_i (clock_i),
		.reset_i (reset_i),
		.req_i   (tag_req),
		.rsp_o   (tag_rsp)
	);

	lease_cache_controller #(.CACHE_SETS(CACHE_SETS)) ctrl_i (
		.clock_i       (clock_i),
		.reset_i       (reset_i),
		.core_req_i    (core_req_i),
		.core_we_i     (core_we_i),
		.core_addr_i   (core_addr_i),
		.core_wdata_i  (core_wdata_i),
		.core_lease_i  (core_lease_i),
		.core_done_o   (core_done_o),
		.core_rdata_o  (core_rdata_o),
		.tag_req_o     (tag_req),
		.tag_rsp_i     (tag_rsp),
		.data_addr_o   (data_addr),
		.data_we_o     (data_we),
		.data_wdata_o  (data_wdata),
		.data_rdata_i  (data_rdata_q),
		.wb            (wb),
		.evt_hit_o     (evt[PERF_HIT]),
		.evt_miss_o    (evt[PERF_MISS]),
		.evt_wb_o      (evt[PERF_WB]),
		.evt_expired_o (evt[PERF_EXPIRED])
	);

	// data array, registered read
	// ------------------------------------------------------------------
	logic [DATA_W-1:0] data_mem [DEPTH];

	always_ff @(posedge clock_i) begin
		if (data_we)
			data_mem[data_addr] <= data_wdata;
		data_rdata_q <= data_mem[data_addr];            // old word on same-cycle write
	end

	// perf counters, saturating
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			cnt_q <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				if (evt[i] && cnt_q[i] != '1)
					cnt_q[i] <= cnt_q[i] + 1'b1;
			end
		end
	end

	assign perf_o = cnt_q[perf_sel_i];

endmodule

//--- source/lease_cache_controller.sv
`timescale 1ns/1ns

module lease_cache_controller #(
	parameter int CACHE_SETS = 16,
	localparam int DA_W = lease_cache_pkg::set_idx_bits(CACHE_SETS) + lease_cache_pkg::WAY_W
		+ lease_cache_pkg::BLOCK_W
)(
	input  logic                                   clock_i,
	input  logic                                   reset_i,
	// core
	input  logic                                   core_req_i,
	input  logic                                   core_we_i,
	input  logic [lease_cache_pkg::WORD_ADDR_W-1:0] core_addr_i,
	input  logic [lease_cache_pkg::DATA_W-1:0]      core_wdata_i,
	input  logic [lease_cache_pkg::LEASE_W-1:0]     core_lease_i,
	output logic                                   core_done_o,
	output logic [lease_cache_pkg::DATA_W-1:0]      core_rdata_o,
	// tag store
	output lease_cache_pkg::tag_req_t              tag_req_o,
	input  lease_cache_pkg::tag_rsp_t              tag_rsp_i,
	// data array, [set|way|word]
	output logic [DA_W-1:0]                        data_addr_o,
	output logic                                   data_we_o,
	output logic [lease_cache_pkg::DATA_W-1:0]      data_wdata_o,
	input  logic [lease_cache_pkg::DATA_W-1:0]      data_rdata_i,
	wb_if.master                                   wb,
	// perf events
	output logic                                   evt_hit_o,
	output logic                                   evt_miss_o,
	output logic                                   evt_wb_o,
	output logic                                   evt_expired_o
);
	import lease_cache_pkg::*;

	localparam int IDX_W = set_idx_bits(CACHE_SETS);
	localparam int TAG_W = WORD_ADDR_W - BLOCK_W - IDX_W;

	typedef enum logic [2:0] {
		S_IDLE, S_LOOKUP, S_WRITEBACK, S_FILL, S_UNCACHED, S_RESPOND
	} state_e;

	state_e             state_q;
	logic [BLOCK_W-1:0] cnt_q;        // word within block
	logic               cyc_q, stb_q;
	logic               miss_q;       // request already counted as miss
	logic               unc_q;        // respond with uncached word
	logic [WAY_W-1:0]   vway_q;
	logic [TAG_W-1:0]   vtag_q;
	logic [DATA_W-1:0]  unc_data_q;

	logic [TAG_W-1:0]   req_tag;
	logic [IDX_W-1:0]   req_idx;
	logic               in_lookup, last_ack;

	assign req_tag   = core_addr_i[WORD_ADDR_W-1 -: TAG_W];
	assign req_idx   = core_addr_i[BLOCK_W +: IDX_W];
	assign in_lookup = state_q == S_LOOKUP;
	assign last_ack  = stb_q && wb.ack && cnt_q == '1;

	// state machine
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			state_q <= S_IDLE;
			cnt_q   <= '0;
			cyc_q   <= 1'b0;
			stb_q   <= 1'b0;
			miss_q  <= 1'b0;
			unc_q   <= 1'b0;
		end else begin
			case (state_q)
				S_IDLE: if (core_req_i) state_q <= S_LOOKUP;
				S_LOOKUP: begin
					if (tag_rsp_i.hit) begin
						state_q <= S_RESPOND;
					end else begin
						miss_q <= 1'b1;
						cnt_q  <= '0;
						cyc_q  <= 1'b1;
						if (core_lease_i == '0) begin            // not cacheable
							state_q <= S_UNCACHED;
							stb_q   <= 1'b1;
						end else if (tag_rsp_i.victim_valid && tag_rsp_i.victim_dirty) begin
							state_q <= S_WRITEBACK;
							stb_q   <= 1'b0;                     // first word still in array
						end else begin
							state_q <= S_FILL;
							stb_q   <= 1'b1;
						end
					end
				end
				S_WRITEBACK: begin
					if (!stb_q) begin
						stb_q <= 1'b1;                           // array read now valid
					end else if (wb.ack) begin
						cnt_q <= cnt_q + 1'b1;
						if (cnt_q == '1)
							state_q <= S_FILL;                   // stb and cyc stay up
						else
							stb_q <= 1'b0;
					end
				end
				S_FILL: begin
					if (wb.ack) begin
						cnt_q <= cnt_q + 1'b1;
						if (cnt_q == '1) begin
							state_q <= S_LOOKUP;                 // replay as a hit
							cyc_q   <= 1'b0;
							stb_q   <= 1'b0;
						end
					end
				end
				S_UNCACHED: begin
					if (wb.ack) begin
						state_q <= S_RESPOND;
						unc_q   <= 1'b1;
						cyc_q   <= 1'b0;
						stb_q   <= 1'b0;
					end
				end
				S_RESPOND: begin
					state_q <= S_IDLE;
					miss_q  <= 1'b0;
					unc_q   <= 1'b0;
				end
				default: state_q <= S_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (in_lookup && !tag_rsp_i.hit) begin
			vway_q <= tag_rsp_i.victim_way;
			vtag_q <= tag_rsp_i.victim_tag[TAG_W-1:0];
		end
		if (state_q == S_UNCACHED && wb.ack)
			unc_data_q <= wb.dat_r;
	end

	// tag store request
	// ------------------------------------------------------------------
	always_comb begin
		tag_req_o           = '0;
		tag_req_o.lookup    = in_lookup;
		tag_req_o.set_idx   = IDX_MAX_W'(req_idx);
		tag_req_o.tag       = TAG_MAX_W'(req_tag);
		tag_req_o.lease     = core_lease_i;
		tag_req_o.update    = in_lookup;
		tag_req_o.set_dirty = in_lookup && core_we_i;
		tag_req_o.way       = vway_q;
		tag_req_o.fill      = state_q == S_FILL && last_ack;
		tag_req_o.clr_dirty = state_q == S_WRITEBACK && last_ack;
	end

	// data array port
	assign data_addr_o  = in_lookup ? {req_idx, tag_rsp_i.hit_way, core_addr_i[BLOCK_W-1:0]}
	                                : {req_idx, vway_q, cnt_q};
	assign data_we_o    = (in_lookup && tag_rsp_i.hit && core_we_i) ||
	                      (state_q == S_FILL && wb.ack);
	assign data_wdata_o = (state_q == S_FILL) ? wb.dat_r : core_wdata_i;

	// wishbone master
	// ------------------------------------------------------------------
	assign wb.cyc = cyc_q;
	assign wb.stb = stb_q;
	assign wb.we  = state_q == S_WRITEBACK || (state_q == S_UNCACHED && core_we_i);
	always_comb begin
		case (state_q)
			S_WRITEBACK: wb.adr = {vtag_q, req_idx, cnt_q};
			S_FILL:      wb.adr = {core_addr_i[WORD_ADDR_W-1:BLOCK_W], cnt_q};
			default:     wb.adr = core_addr_i;               // uncached single word
		endcase
	end
	assign wb.dat_w = (state_q == S_WRITEBACK) ? data_rdata_i : core_wdata_i;

	// core side
	assign core_done_o  = state_q == S_RESPOND;
	assign core_rdata_o = unc_q ? unc_data_q : data_rdata_i;

	// one strobe per request
	assign evt_hit_o     = in_lookup && tag_rsp_i.hit && !miss_q;
	assign evt_miss_o    = in_lookup && !tag_rsp_i.hit && !miss_q;
	assign evt_wb_o      = state_q == S_WRITEBACK && last_ack;
	assign evt_expired_o = evt_miss_o && core_lease_i != '0 && tag_rsp_i.victim_expired;

endmodule

//--- source/lease_cache_pkg.sv
package lease_cache_pkg;

	// ------------------------------------------------------------------
	// widths
	// ------------------------------------------------------------------
	localparam int WORD_ADDR_W = 16;                      // word address
	localparam int DATA_W      = 32;
	localparam int BLOCK_W     = 2;                       // 4 words per block
	localparam int WAYS        = 4;
	localparam int WAY_W       = $clog2(WAYS);
	localparam int LEASE_W     = 8;

	// widest set index and tag, for two sets
	localparam int IDX_MAX_W = WORD_ADDR_W - BLOCK_W - 1;
	localparam int TAG_MAX_W = WORD_ADDR_W - BLOCK_W - 1;

	function automatic int set_idx_bits(input int sets);
		return $clog2(sets);
	endfunction

	// controller -> tag store
	typedef struct packed {
		logic                 lookup;     // lookup cycle, qualifies update and set_dirty
		logic [IDX_MAX_W-1:0] set_idx;    // zero extended
		logic [TAG_MAX_W-1:0] tag;        // zero extended
		logic [LEASE_W-1:0]   lease;
		logic                 update;     // renew lease of hit way
		logic                 fill;       // install tag into way
		logic [WAY_W-1:0]     way;
		logic                 set_dirty;  // hit write
		logic                 clr_dirty;  // writeback done
	} tag_req_t;

	// tag store -> controller
	typedef struct packed {
		logic                 hit;
		logic [WAY_W-1:0]     hit_way;
		logic [WAY_W-1:0]     victim_way;
		logic                 victim_valid;
		logic                 victim_dirty;
		logic [TAG_MAX_W-1:0] victim_tag;
		logic                 victim_expired;  // valid with lease run out
	} tag_rsp_t;

	typedef enum logic [1:0] {
		PERF_HIT     = 2'd0,
		PERF_MISS    = 2'd1,
		PERF_WB      = 2'd2,
		PERF_EXPIRED = 2'd3
	} perf_sel_e;

endpackage

//--- source/lease_cache_top.sv
`timescale 1ns/1ns

module lease_cache_top #(
	parameter int CACHE_SETS = 16
)(
	input  logic                                   clock_i,
	input  logic                                   reset_i,
	// core 0
	input  logic                                   core0_req_i,
	input  logic                                   core0_we_i,
	input  logic [lease_cache_pkg::WORD_ADDR_W-1:0] core0_addr_i,
	input  logic [lease_cache_pkg::DATA_W-1:0]      core0_wdata_i,
	input  logic [lease_cache_pkg::LEASE_W-1:0]     core0_lease_i,
	output logic                                   core0_done_o,
	output logic [lease_cache_pkg::DATA_W-1:0]      core0_rdata_o,
	// core 1
	input  logic                                   core1_req_i,
	input  logic                                   core1_we_i,
	input  logic [lease_cache_pkg::WORD_ADDR_W-1:0] core1_addr_i,
	input  logic [lease_cache_pkg::DATA_W-1:0]      core1_wdata_i,
	input  logic [lease_cache_pkg::LEASE_W-1:0]     core1_lease_i,
	output logic                                   core1_done_o,
	output logic [lease_cache_pkg::DATA_W-1:0]      core1_rdata_o,
	// perf readout
	input  lease_cache_pkg::perf_sel_e             perf0_sel_i,
	output logic [31:0]                            perf0_o,
	input  lease_cache_pkg::perf_sel_e             perf1_sel_i,
	output logic [31:0]                            perf1_o,
	// external memory
	output logic                                   mem_cyc_o,
	output logic                                   mem_stb_o,
	output logic                                   mem_we_o,
	output logic [lease_cache_pkg::WORD_ADDR_W-1:0] mem_adr_o,
	output logic [lease_cache_pkg::DATA_W-1:0]      mem_dat_o,
	input  logic [lease_cache_pkg::DATA_W-1:0]      mem_dat_i,
	input  logic                                   mem_ack_i
);

	wb_if bus0_if ();   // cache 0 to arbiter
	wb_if bus1_if ();   // cache 1 to arbiter

	lease_cache_4w #(.CACHE_SETS(CACHE_SETS)) cache0_i (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.core_req_i   (core0_req_i),
		.core_we_i    (core0_we_i),
		.core_addr_i  (core0_addr_i),
		.core_wdata_i (core0_wdata_i),
		.core_lease_i (core0_lease_i),
		.core_done_o  (core0_done_o),
		.core_rdata_o (core0_rdata_o),
		.perf_sel_i   (perf0_sel_i),
		.perf_o       (perf0_o),
		.wb           (bus0_if.master)
	);

	lease_cache_4w #(.CACHE_SETS(CACHE_SETS)) cache1_i (
		.clock_i      (clock_i),
		.reset_i      (reset_i),
		.core_req_i   (core1_req_i),
		.core_we_i    (core1_we_i),
		.core_addr_i  (core1_addr_i),
		.core_wdata_i (core1_wdata_i),
		.core_lease_i (core1_lease_i),
		.core_done_o  (core1_done_o),
		.core_rdata_o (core1_rdata_o),
		.perf_sel_i   (perf1_sel_i),
		.perf_o       (perf1_o),
		.wb           (bus1_if.master)
	);

	// shared memory port
	// ------------------------------------------------------------------
	wb_arbiter arb_i (
		.clock_i   (clock_i),
		.reset_i   (reset_i),
		.m0        (bus0_if.slave),
		.m1        (bus1_if.slave),
		.mem_cyc_o (mem_cyc_o),
		.mem_stb_o (mem_stb_o),
		.mem_we_o  (mem_we_o),
		.mem_adr_o (mem_adr_o),
		.mem_dat_o (mem_dat_o),
		.mem_dat_i (mem_dat_i),
		.mem_ack_i (mem_ack_i)
	);

endmodule

//--- source/lease_tag_store.sv
`timescale 1ns/1ns

module lease_tag_store #(
	parameter int CACHE_SETS = 16
)(
	input  logic                      clock_i,
	input  logic                      reset_i,
	input  lease_cache_pkg::tag_req_t req_i,
	output lease_cache_pkg::tag_rsp_t rsp_o
);
	import lease_cache_pkg::*;

	localparam int IDX_W = set_idx_bits(CACHE_SETS);
	localparam int TAG_W = WORD_ADDR_W - BLOCK_W - IDX_W;

	// store
	// ------------------------------------------------------------------
	logic [TAG_W-1:0] tag_q [CACHE_SETS][WAYS];               // tag per set and way
	logic [CACHE_SETS-1:0][WAYS-1:0]              valid_q;
	logic [CACHE_SETS-1:0][WAYS-1:0]              dirty_q;
	logic [CACHE_SETS-1:0][WAYS-1:0][LEASE_W-1:0] lease_q;

	logic [IDX_W-1:0] idx;
	logic [TAG_W-1:0] tag;
	logic             hit;
	logic [WAY_W-1:0] hit_way;
	logic             vic_found;
	logic [WAY_W-1:0] vic_way;
	logic [LEASE_W-1:0] min_lease;

	assign idx = req_i.set_idx[IDX_W-1:0];
	assign tag = req_i.tag[TAG_W-1:0];

	// lookup, combinational from req
	// ------------------------------------------------------------------
	always_comb begin
		hit     = 1'b0;
		hit_way = '0;
		for (int w = 0; w < WAYS; w++) begin
			if (valid_q[idx][w] && tag_q[idx][w] == tag) begin
				hit     = 1'b1;
				hit_way = WAY_W'(w);
			end
		end
	end

	// victim: lowest invalid or expired way, else smallest lease
	always_comb begin
		vic_found = 1'b0;
		vic_way   = '0;
		min_lease = '1;
		for (int w = 0; w < WAYS; w++) begin
			if (!vic_found && (!valid_q[idx][w] || lease_q[idx][w] == '0)) begin
				vic_found = 1'b1;
				vic_way   = WAY_W'(w);
			end
		end
		if (!vic_found) begin
			for (int w = 0; w < WAYS; w++) begin
				if (lease_q[idx][w] < min_lease) begin  // strict, lowest index wins ties
					min_lease = lease_q[idx][w];
					vic_way   = WAY_W'(w);
				end
			end
		end
	end

	assign rsp_o.hit            = hit;
	assign rsp_o.hit_way        = hit_way;
	assign rsp_o.victim_way     = vic_way;
	assign rsp_o.victim_valid   = valid_q[idx][vic_way];
	assign rsp_o.victim_dirty   = valid_q[idx][vic_way] & dirty_q[idx][vic_way];
	assign rsp_o.victim_tag     = TAG_MAX_W'(tag_q[idx][vic_way]);
	assign rsp_o.victim_expired = valid_q[idx][vic_way] && lease_q[idx][vic_way] == '0;

	// registered updates
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (req_i.fill)
			tag_q[idx][req_i.way] <= tag;
	end

	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			valid_q <= '0;
			dirty_q <= '0;
			lease_q <= '0;
		end else begin
			if (req_i.lookup && hit) begin
				if (req_i.update) begin
					for (int w = 0; w < WAYS; w++) begin
						if (w == int'(hit_way))
							lease_q[idx][w] <= req_i.lease;                  // renew
						else if (lease_q[idx][w] != '0)
							lease_q[idx][w] <= lease_q[idx][w] - 1'b1;       // age the rest
					end
				end
				if (req_i.set_dirty)
					dirty_q[idx][hit_way] <= 1'b1;
			end
			if (req_i.clr_dirty)
				dirty_q[idx][req_i.way] <= 1'b0;
			if (req_i.fill)
				valid_q[idx][req_i.way] <= 1'b1;
		end
	end

endmodule

//--- source/wb_arbiter.sv
`timescale 1ns/1ns

// round robin, two wishbone masters onto one memory port
module wb_arbiter (
	input  logic                                   clock_i,
	input  logic                                   reset_i,
	wb_if.slave                                    m0,
	wb_if.slave                                    m1,
	output logic                                   mem_cyc_o,
	output logic                                   mem_stb_o,
	output logic                                   mem_we_o,
	output logic [lease_cache_pkg::WORD_ADDR_W-1:0] mem_adr_o,
	output logic [lease_cache_pkg::DATA_W-1:0]      mem_dat_o,
	input  logic [lease_cache_pkg::DATA_W-1:0]      mem_dat_i,
	input  logic                                   mem_ack_i
);

	logic busy_q;   // bus granted
	logic sel_q;    // granted master
	logic last_q;   // master served last
	logic gnt_cyc;

	assign gnt_cyc = sel_q ? m1.cyc : m0.cyc;

	// grant
	// ------------------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (reset_i) begin
			busy_q <= 1'b0;
			sel_q  <= 1'b0;
			last_q <= 1'b1;                          // m0 first on a tie
		end else if (!busy_q) begin
			if (m0.cyc && (!m1.cyc || last_q)) begin
				busy_q <= 1'b1;
				sel_q  <= 1'b0;
			end else if (m1.cyc) begin
				busy_q <= 1'b1;
				sel_q  <= 1'b1;
			end
		end else if (!gnt_cyc) begin
			busy_q <= 1'b0;                          // owner let go
			last_q <= sel_q;
		end
	end

	// memory side
	// ------------------------------------------------------------------
	assign mem_cyc_o = busy_q && gnt_cyc;
	assign mem_stb_o = busy_q && (sel_q ? m1.stb : m0.stb);
	assign mem_we_o  = busy_q && (sel_q ? m1.we : m0.we);
	assign mem_adr_o = sel_q ? m1.adr : m0.adr;
	assign mem_dat_o = sel_q ? m1.dat_w : m0.dat_w;

	// ack and read data to the owner only
	assign m0.ack   = busy_q && !sel_q && mem_ack_i;
	assign m1.ack   = busy_q && sel_q && mem_ack_i;
	assign m0.dat_r = (busy_q && !sel_q) ? mem_dat_i : '0;
	assign m1.dat_r = (busy_q && sel_q) ? mem_dat_i : '0;

endmodule

//--- source/wb_if.sv
`timescale 1ns/1ns

// wishbone classic, single word transfers
interface wb_if;
	import lease_cache_pkg::*;

	logic                   cyc;
	logic                   stb;
	logic                   we;
	logic [WORD_ADDR_W-1:0] adr;
	logic [DATA_W-1:0]      dat_w;  // master to slave
	logic [DATA_W-1:0]      dat_r;  // slave to master
	logic                   ack;

	modport master (
		output cyc, stb, we, adr, dat_w,
		input  dat_r, ack
	);

	modport slave (
		input  cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface
